// ==== ifu_cfg.svh ====
`ifndef IFU_CFG_SVH
`define IFU_CFG_SVH

//************************************************
// Fetch path sizing
//************************************************

// Byte address width of the fetch bus
`define IFU_ADDR_W     32

// Width of one fetched word
`define IFU_WORD_W     32

`define IFU_FB_DEPTH   4     // Fetch buffer entries
`define IFU_MAX_OUTST  2     // Reads in flight at once

`endif

// ==== ifu_pkg.sv ====
`default_nettype none
`include "ifu_cfg.svh"

package ifu_pkg;

   //************************************************
   // Fetch buffer entry
   //************************************************
   typedef struct packed {
      logic [`IFU_WORD_W-1:0] word;     // Fetched word as returned by the bus
      logic [`IFU_ADDR_W-1:1] pc;       // Halfword pc where use of the word starts
      logic                   fault;    // Bus error on this word
   } ifu_fetch_t;

   // Two 16-bit parcels of one word, high parcel first
   typedef struct packed {
      logic [15:0] hi;                  // Parcel at byte offset 2
      logic [15:0] lo;                  // Parcel at byte offset 0
   } ifu_parcel_t;

   typedef union packed {
      logic [`IFU_WORD_W-1:0] full;     // Word as one full instruction
      ifu_parcel_t            half;     // Word as two parcels
   } ifu_word_u;

   //************************************************
   // Decode side and redirect
   //************************************************
   typedef struct packed {
      logic [`IFU_WORD_W-1:0] instr;    // Compressed form is zero-extended
      logic [`IFU_ADDR_W-1:1] pc;
      logic                   pc4;      // 4-byte instruction
      logic                   fault;    // Access fault
   } ifu_instr_t;

   typedef struct packed {
      logic                   valid;    // One-cycle redirect strobe
      logic [`IFU_ADDR_W-1:1] pc;       // Restart pc, any halfword
   } ifu_flush_t;

endpackage

`default_nettype wire

// ==== ifu_fetch_ctl.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "ifu_cfg.svh"

module ifu_fetch_ctl
   import ifu_pkg::*;
(
   input  logic                                 clk,
   input  logic                                 arst_n,
   input  ifu_flush_t                           flush,      // Redirect
   output logic [`IFU_ADDR_W-1:0]               araddr,     // AXI4-Lite read address
   output logic                                 arvalid,
   input  logic                                 arready,
   input  logic [`IFU_WORD_W-1:0]               rdata,      // AXI4-Lite read data
   input  logic [1:0]                           rresp,
   input  logic                                 rvalid,
   output logic                                 rready,
   input  logic [$clog2(`IFU_FB_DEPTH+1)-1:0]   fb_count,   // Buffer occupancy
   output logic                                 fb_push,
   output ifu_fetch_t                           fb_wdata
);

   localparam int CW = $clog2(`IFU_FB_DEPTH+1);
   localparam int OW = $clog2(`IFU_MAX_OUTST+1);
   localparam int QW = (`IFU_MAX_OUTST > 1) ? $clog2(`IFU_MAX_OUTST) : 1;

   logic [`IFU_ADDR_W-1:1] fetch_pc;                       // Next pc to request
   logic                   run_q;                          // Low only during reset
   logic [OW-1:0]          outst_q;                        // Reads in flight
   logic [OW-1:0]          outst_d;
   logic [OW-1:0]          discard_q;                      // Responses still to drop
   logic [`IFU_ADDR_W-1:1] pcq [`IFU_MAX_OUTST];           // Start pcs of reads in flight
   logic [QW-1:0]          wptr_q;
   logic [QW-1:0]          rptr_q;
   logic [CW:0]            credit_sum;
   logic                   ar_fire;
   logic                   r_fire;

   function automatic logic [QW-1:0] qnext(input logic [QW-1:0] p);
      qnext = (p == QW'(`IFU_MAX_OUTST-1)) ? '0 : p + 1'b1;   // Wrap at queue end
   endfunction

   //************************************************
   // Read address issue
   //************************************************
   // Buffer entries plus reads in flight only grow on an address accept
   // so arvalid holds until arready once raised
   assign credit_sum = (CW+1)'(fb_count) + (CW+1)'(outst_q);
   assign arvalid    = run_q && (credit_sum < (CW+1)'(`IFU_FB_DEPTH))
                             && (outst_q < OW'(`IFU_MAX_OUTST));
   assign araddr     = {fetch_pc[`IFU_ADDR_W-1:2], 2'b00};   // Word aligned
   assign ar_fire    = arvalid && arready;

   //************************************************
   // Read response
   //************************************************
   assign rready         = 1'b1;                           // Always sink responses
   assign r_fire         = rvalid && rready;
   assign fb_push        = r_fire && (discard_q == '0) && !flush.valid;
   assign fb_wdata.word  = rdata;
   assign fb_wdata.pc    = pcq[rptr_q];                    // Oldest read in flight
   assign fb_wdata.fault = |rresp;                         // SLVERR or DECERR

   assign outst_d = outst_q + OW'(ar_fire) - OW'(r_fire);

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         run_q     <= 1'b0;
         fetch_pc  <= '0;                                  // Boot from address 0
         outst_q   <= '0;
         discard_q <= '0;
         wptr_q    <= '0;
         rptr_q    <= '0;
      end else begin
         run_q   <= 1'b1;
         outst_q <= outst_d;
         if (ar_fire) begin
            wptr_q <= qnext(wptr_q);
         end
         if (r_fire) begin
            rptr_q <= qnext(rptr_q);                       // Dropped reads pop too
         end
         if (flush.valid) begin
            fetch_pc  <= flush.pc;                         // Restart at target
            discard_q <= outst_d;                          // Everything in flight is stale
         end else begin
            if (ar_fire) begin
               fetch_pc <= {fetch_pc[`IFU_ADDR_W-1:2] + 1'b1, 1'b0};
            end
            if (r_fire && (discard_q != '0)) begin
               discard_q <= discard_q - 1'b1;
            end
         end
      end
   end

   always_ff @(posedge clk) begin
      if (ar_fire) begin
         pcq[wptr_q] <= fetch_pc;                          // First read after flush keeps pc[1]
      end
   end

   // Request held with fixed address until the slave takes it
   a_ar_hold: assert property (@(posedge clk) disable iff (!arst_n)
      arvalid && !arready && !flush.valid |=> arvalid && $stable(araddr));

endmodule

`default_nettype wire

// ==== ifu_fetch_buf.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "ifu_cfg.svh"

module ifu_fetch_buf
   import ifu_pkg::*;
(
   input  logic                                 clk,
   input  logic                                 arst_n,
   input  ifu_flush_t                           flush,      // Clears all entries
   input  logic                                 fb_push,
   input  ifu_fetch_t                           fb_wdata,
   input  logic                                 fb_pop,
   output logic                                 fb_valid,   // Head entry present
   output ifu_fetch_t                           fb_rdata,   // Head entry
   output logic [$clog2(`IFU_FB_DEPTH+1)-1:0]   fb_count
);

   localparam int CW = $clog2(`IFU_FB_DEPTH+1);
   localparam int AW = (`IFU_FB_DEPTH > 1) ? $clog2(`IFU_FB_DEPTH) : 1;

   ifu_fetch_t    mem [`IFU_FB_DEPTH];                     // Entry storage
   logic [AW-1:0] wptr_q;
   logic [AW-1:0] rptr_q;
   logic [CW-1:0] count_q;
   logic          do_push;
   logic          do_pop;

   function automatic logic [AW-1:0] pnext(input logic [AW-1:0] p);
      pnext = (p == AW'(`IFU_FB_DEPTH-1)) ? '0 : p + 1'b1;
   endfunction

   assign do_push  = fb_push && !flush.valid;
   assign do_pop   = fb_pop && fb_valid && !flush.valid;
   assign fb_valid = (count_q != '0);
   assign fb_rdata = mem[rptr_q];
   assign fb_count = count_q;

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         wptr_q  <= '0;
         rptr_q  <= '0;
         count_q <= '0;
      end else if (flush.valid) begin
         wptr_q  <= '0;                                    // Drop every entry
         rptr_q  <= '0;
         count_q <= '0;
      end else begin
         if (do_push) begin
            wptr_q <= pnext(wptr_q);
         end
         if (do_pop) begin
            rptr_q <= pnext(rptr_q);
         end
         count_q <= count_q + CW'(do_push) - CW'(do_pop);
      end
   end

   always_ff @(posedge clk) begin
      if (do_push) begin
         mem[wptr_q] <= fb_wdata;
      end
   end

   // Fetch credit keeps the controller from pushing into a full buffer
   a_no_overflow: assert property (@(posedge clk) disable iff (!arst_n)
      fb_push |-> (count_q != CW'(`IFU_FB_DEPTH)));

endmodule

`default_nettype wire

// ==== ifu_align.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "ifu_cfg.svh"

module ifu_align
   import ifu_pkg::*;
(
   input  logic        clk,
   input  logic        arst_n,
   input  ifu_flush_t  flush,          // Drops held parcel and output
   input  logic        fb_valid,
   input  ifu_fetch_t  fb_rdata,       // Buffer head
   output logic        fb_pop,         // Head word fully used
   output ifu_instr_t  instr,          // To decode
   output logic        instr_valid,
   input  logic        instr_ready
);

   ifu_word_u              w;                      // Head word, both views
   logic [`IFU_ADDR_W-1:2] waddr;                  // Word address of head
   logic                   pos_hi;                 // Next parcel is the high one
   logic                   lo_used_q;              // Low parcel of head consumed
   logic                   held_v_q;               // First half of a straddler held
   logic [15:0]            held_par_q;
   logic [`IFU_ADDR_W-1:1] held_pc_q;
   logic                   can_load;               // Output stage free this cycle
   logic                   step;
   logic                   emit;
   logic                   pop_c;
   logic                   hold_c;
   logic                   lo_used_d;
   ifu_instr_t             instr_d;
   ifu_instr_t             instr_q;
   logic                   valid_q;

   // Parcel is RVC unless its two low bits are both one
   function automatic logic is_rvc(input logic [15:0] p);
      is_rvc = (p[1:0] != 2'b11);
   endfunction

   assign w        = fb_rdata.word;
   assign waddr    = fb_rdata.pc[`IFU_ADDR_W-1:2];
   assign pos_hi   = fb_rdata.pc[1] | lo_used_q;   // Flush target may start mid word
   assign can_load = !valid_q || instr_ready;
   assign step     = can_load && fb_valid && !flush.valid;
   assign fb_pop   = step && pop_c;

   //************************************************
   // Parcel selection
   //************************************************
   always_comb begin
      emit      = 1'b1;
      pop_c     = 1'b0;
      hold_c    = 1'b0;
      lo_used_d = 1'b0;
      instr_d   = '0;
      if (fb_rdata.fault) begin
         instr_d.pc    = held_v_q ? held_pc_q : {waddr, pos_hi};   // Start of faulting instr
         instr_d.pc4   = held_v_q;
         instr_d.fault = 1'b1;                     // Value stays zero
         pop_c         = 1'b1;                     // Held parcel dropped below
      end else if (held_v_q) begin
         instr_d.instr = {w.half.lo, held_par_q};  // Join straddling halves
         instr_d.pc    = held_pc_q;
         instr_d.pc4   = 1'b1;
         lo_used_d     = 1'b1;                     // High parcel still pending
      end else if (!pos_hi) begin
         instr_d.pc = {waddr, 1'b0};
         if (is_rvc(w.half.lo)) begin
            instr_d.instr = {16'h0000, w.half.lo};
            lo_used_d     = 1'b1;
         end else begin
            instr_d.instr = w.full;                // Aligned full instruction
            instr_d.pc4   = 1'b1;
            pop_c         = 1'b1;
         end
      end else begin
         instr_d.pc = {waddr, 1'b1};
         pop_c      = 1'b1;
         if (is_rvc(w.half.hi)) begin
            instr_d.instr = {16'h0000, w.half.hi};
         end else begin
            emit   = 1'b0;                         // Wait for next word
            hold_c = 1'b1;
         end
      end
   end

   //************************************************
   // Output stage and parcel hold
   //************************************************
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         valid_q   <= 1'b0;
         lo_used_q <= 1'b0;
         held_v_q  <= 1'b0;
      end else if (flush.valid) begin
         valid_q   <= 1'b0;
         lo_used_q <= 1'b0;
         held_v_q  <= 1'b0;
      end else begin
         if (can_load) begin
            valid_q <= step && emit;
         end
         if (step) begin
            lo_used_q <= lo_used_d;
            held_v_q  <= hold_c;                   // Fault or join clears it
         end
      end
   end

   always_ff @(posedge clk) begin
      if (step && emit) begin
         instr_q <= instr_d;
      end
      if (step && hold_c) begin
         held_par_q <= w.half.hi;
         held_pc_q  <= {waddr, 1'b1};
      end
   end

   assign instr       = instr_q;
   assign instr_valid = valid_q;

   // Decode sees a steady instruction under back-pressure
   a_instr_hold: assert property (@(posedge clk) disable iff (!arst_n)
      valid_q && !instr_ready && !flush.valid |=> valid_q && $stable(instr_q));

endmodule

`default_nettype wire

// ==== ifu_top.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "ifu_cfg.svh"

module ifu_top
   import ifu_pkg::*;
(
   input  logic                     clk,
   input  logic                     arst_n,
   input  ifu_flush_t               flush,          // Redirect from outside
   output logic [`IFU_ADDR_W-1:0]   araddr,         // AXI4-Lite ar channel
   output logic                     arvalid,
   input  logic                     arready,
   input  logic [`IFU_WORD_W-1:0]   rdata,          // AXI4-Lite r channel
   input  logic [1:0]               rresp,
   input  logic                     rvalid,
   output logic                     rready,
   output ifu_instr_t               instr,          // Decode handshake
   output logic                     instr_valid,
   input  logic                     instr_ready
);

   logic                                fb_push;
   ifu_fetch_t                          fb_wdata;
   logic                                fb_pop;
   logic                                fb_valid;
   ifu_fetch_t                          fb_rdata;
   logic [$clog2(`IFU_FB_DEPTH+1)-1:0]  fb_count;   // Feeds fetch credit

   //************************************************
   // Producer, buffer, consumer
   //************************************************
   ifu_fetch_ctl u_fetch_ctl (
      .clk(clk), .arst_n(arst_n), .flush(flush),
      .araddr(araddr), .arvalid(arvalid), .arready(arready),
      .rdata(rdata), .rresp(rresp), .rvalid(rvalid), .rready(rready),
      .fb_count(fb_count), .fb_push(fb_push), .fb_wdata(fb_wdata)
   );

   ifu_fetch_buf u_fetch_buf (
      .clk(clk), .arst_n(arst_n), .flush(flush),
      .fb_push(fb_push), .fb_wdata(fb_wdata), .fb_pop(fb_pop),
      .fb_valid(fb_valid), .fb_rdata(fb_rdata), .fb_count(fb_count)
   );

   ifu_align u_align (
      .clk(clk), .arst_n(arst_n), .flush(flush),
      .fb_valid(fb_valid), .fb_rdata(fb_rdata), .fb_pop(fb_pop),
      .instr(instr), .instr_valid(instr_valid), .instr_ready(instr_ready)
   );

endmodule

`default_nettype wire

// ==== tb_ifu.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "ifu_cfg.svh"

module tb_ifu
   import ifu_pkg::*;
();

   localparam int CLK_PERIOD = 40;                         // ns
   localparam int MAX_REC    = 64;                         // Records in the pattern file
   localparam int MEM_WORDS  = 256;                        // 1 KiB of loadable memory

   logic                   clk;
   logic                   arst_n;
   ifu_flush_t             flush;
   logic [`IFU_ADDR_W-1:0] araddr;
   logic                   arvalid;
   logic                   arready;
   logic [`IFU_WORD_W-1:0] rdata;
   logic [1:0]             rresp;
   logic                   rvalid;
   logic                   rready;
   ifu_instr_t             instr;
   logic                   instr_valid;
   logic                   instr_ready;

   logic [71:0]            rec [MAX_REC];                  // Kind, a, b, flags
   logic [31:0]            mem_data [MEM_WORDS];
   logic                   mem_err [MEM_WORDS];            // Word answers with SLVERR
   logic [31:0]            exp_pc [MAX_REC];
   logic [31:0]            exp_val [MAX_REC];
   logic [3:0]             exp_flg [MAX_REC];              // Bit 1 pc4, bit 0 fault
   int                     fl_after [MAX_REC];             // Instructions taken before flush
   logic [31:0]            fl_pc [MAX_REC];
   int                     n_exp;
   int                     n_fl;
   int                     n_done;
   int                     fl_idx;
   int                     r_wait;                         // Cycles until next response
   logic [31:0]            ar_q [$];                       // Accepted read addresses
   logic [31:0]            exp_araddr;                     // Next word the fetch must request
   logic [31:0]            rnd;                            // One draw per cycle for both sides
   integer                 seed = 45;

   ifu_top UUT (
      .clk(clk), .arst_n(arst_n), .flush(flush),
      .araddr(araddr), .arvalid(arvalid), .arready(arready),
      .rdata(rdata), .rresp(rresp), .rvalid(rvalid), .rready(rready),
      .instr(instr), .instr_valid(instr_valid), .instr_ready(instr_ready)
   );

   function automatic logic [31:0] word_fill(input logic [31:0] addr);
      word_fill = addr ^ 32'h5EED_0013;                    // Every address bit shows up
   endfunction

   function automatic logic [31:0] mem_word(input logic [31:0] addr);
      mem_word = (addr < 32'(MEM_WORDS*4)) ? mem_data[addr[9:2]] : word_fill(addr);
   endfunction

   function automatic logic mem_fault(input logic [31:0] addr);
      mem_fault = (addr < 32'(MEM_WORDS*4)) ? mem_err[addr[9:2]] : 1'b0;
   endfunction

   task automatic compare_value(input string name, input logic [31:0] expected,
                                input logic [31:0] actual);
      if (expected !== actual) begin
         $display("mismatch %s expected %h actual %h", name, expected, actual);
         $display("SIMULATION FAILED");
         $fatal(1, "stopped at first wrong value");
      end
   endtask

   //************************************************
   // Pattern load
   //************************************************
   initial begin : load
      logic [3:0]  kind;
      logic [31:0] a;
      logic [31:0] b;
      logic [3:0]  f;
      n_exp = 0;
      n_fl  = 0;
      for (int i = 0; i < MAX_REC; i++) begin
         rec[i] = '0;                                      // Kind 0 marks an empty slot
      end
      for (int i = 0; i < MEM_WORDS; i++) begin
         mem_data[i] = word_fill(32'(i) * 4);
         mem_err[i]  = 1'b0;
      end
      $readmemh("ifu_patterns.txt", rec);
      for (int i = 0; i < MAX_REC; i++) begin
         kind = rec[i][71:68];
         a    = rec[i][67:36];
         b    = rec[i][35:4];
         f    = rec[i][3:0];
         case (kind)
            4'h1: begin                                    // Memory word
               mem_data[a[9:2]] = b;
               mem_err[a[9:2]]  = f[0];
            end
            4'h2: begin                                    // Flush command
               fl_after[n_fl] = int'(a);
               fl_pc[n_fl]    = b;
               n_fl++;
            end
            4'h3: begin                                    // Expected instruction
               exp_pc[n_exp]  = a;
               exp_val[n_exp] = b;
               exp_flg[n_exp] = f;
               n_exp++;
            end
            default: ;
         endcase
      end
      if (n_exp == 0) begin
         $display("pattern file holds no expected instructions");
         $display("SIMULATION FAILED");
         $fatal(1, "empty pattern file");
      end
   end

   //************************************************
   // Clock, reset and watchdog
   //************************************************
   initial begin : clock_gen
      clk = 1'b0;
      forever #(CLK_PERIOD/2) clk = ~clk;
   end

   initial begin : reset_seq
      arst_n      = 1'b0;
      flush       = '0;
      arready     = 1'b0;
      rdata       = '0;
      rresp       = 2'b00;
      rvalid      = 1'b0;
      instr_ready = 1'b0;
      n_done      = 0;
      fl_idx      = 0;
      r_wait      = 0;
      exp_araddr  = '0;                                    // Fetch boots from address 0
      repeat (4) @(posedge clk);
      arst_n <= 1'b1;
   end

   initial begin : watchdog
      #1;                                                  // Pattern count known by now
      #(n_exp * 40 * CLK_PERIOD);
      $display("watchdog: instruction stream not complete after %0d ns", n_exp * 40 * CLK_PERIOD);
      $display("SIMULATION FAILED");
      $fatal(1, "timeout");
   end

   always @(posedge clk) begin : random_draw
      rnd <= $random(seed);                                // Read by slave and decode side
   end

   //************************************************
   // AXI4-Lite read slave
   //************************************************
   always @(posedge clk) begin : axi_mem
      logic [31:0] addr;
      if (arst_n) begin
         if (arvalid && arready) begin
            compare_value("araddr", exp_araddr, araddr);
            exp_araddr = exp_araddr + 32'd4;               // One word per request
            ar_q.push_back(araddr);                        // Answered in order
         end
         if (flush.valid) begin
            exp_araddr = {flush.pc[31:2], 2'b00};          // Word holding the target
         end
         if (rvalid && rready) begin
            rvalid <= 1'b0;
         end
         if ((!rvalid || rready) && (ar_q.size() != 0)) begin
            if (r_wait != 0) begin
               r_wait = r_wait - 1;
            end else begin
               addr = ar_q.pop_front();
               rvalid <= 1'b1;
               rdata  <= mem_word(addr);
               rresp  <= mem_fault(addr) ? 2'b10 : 2'b00;  // SLVERR on marked words
               r_wait = int'(rnd[3:2]);                    // 0 to 3 cycles
            end
         end
         arready <= rnd[0] | rnd[1];                       // High about 3 cycles in 4
      end
   end

   //************************************************
   // Decode side, flush and checks
   //************************************************
   always @(posedge clk) begin : decode_side
      if (arst_n) begin
         if (instr_valid && instr_ready) begin
            compare_value($sformatf("instr %0d pc", n_done), exp_pc[n_done],
                          {instr.pc, 1'b0});
            compare_value($sformatf("instr %0d value", n_done), exp_val[n_done],
                          instr.instr);
            compare_value($sformatf("instr %0d pc4", n_done), 32'(exp_flg[n_done][1]),
                          32'(instr.pc4));
            compare_value($sformatf("instr %0d fault", n_done), 32'(exp_flg[n_done][0]),
                          32'(instr.fault));
            n_done++;
         end
         if (n_done == n_exp) begin
            $display("SIMULATION PASSED");
            $finish;
         end else begin
            flush       <= '0;
            instr_ready <= rnd[4] | rnd[5];                // Random back-pressure
            if ((fl_idx < n_fl) && (n_done == fl_after[fl_idx])) begin
               flush.valid <= 1'b1;                        // One-cycle redirect
               flush.pc    <= fl_pc[fl_idx][31:1];
               instr_ready <= 1'b0;                        // Nothing taken during flush
               fl_idx++;
            end
         end
      end
   end

endmodule

`default_nettype wire

// ==== ifu_patterns.txt ====
// Record kind_a_b_flags in hex, 72 bits. Kind 1 memory word: a address, b data, flags 1 error
// Kind 2 flush: a instructions taken first, b target. Kind 3 expected: a pc, b value, flags pc4 fault

// Full instructions from address 0
1_00000000_00000013_0
1_00000004_00100093_0
1_00000008_00200113_0
1_0000000C_00300193_0
// Two compressed, one compressed then a full one straddling 0x16
1_00000010_45854501_0
1_00000014_86330505_0
1_00000018_808200A5_0
1_0000001C_00400213_0
// Flush target 0x42 starts in the high parcel
1_00000040_4611FFFF_0
1_00000044_02930691_0
1_00000048_47010050_0
1_0000004C_00600313_0
1_00000050_12345678_1
1_00000054_00700393_0
1_00000058_04134781_0
1_0000005C_BAD0BAD0_1
1_00000060_00800413_0
1_00000080_00900493_0
1_00000084_00A00513_0
// Flushes
2_0000000A_00000042_0
2_00000014_00000080_0
// Expected stream
3_00000000_00000013_2
3_00000004_00100093_2
3_00000008_00200113_2
3_0000000C_00300193_2
3_00000010_00004501_0
3_00000012_00004585_0
3_00000014_00000505_0
3_00000016_00A58633_2
3_0000001A_00008082_0
3_0000001C_00400213_2
3_00000042_00004611_0
3_00000044_00000691_0
3_00000046_00500293_2
3_0000004A_00004701_0
3_0000004C_00600313_2
3_00000050_00000000_1
3_00000054_00700393_2
3_00000058_00004781_0
3_0000005A_00000000_3
3_00000060_00800413_2
3_00000080_00900493_2
3_00000084_00A00513_2

// ==== ifu_top.f ====
+incdir+.
ifu_pkg.sv
ifu_fetch_ctl.sv
ifu_fetch_buf.sv
ifu_align.sv
ifu_top.sv
tb_ifu.sv

// ==== Makefile ====
# Verilator build and run of the fetch unit testbench

TOP       ?= tb_ifu
VERILATOR ?= verilator
FLAGS     ?= --binary --assert -j 0
FILELIST  ?= ifu_top.f
OBJ_DIR   ?= obj_dir

SRCS := $(shell grep -v '^+' $(FILELIST)) $(wildcard *.svh)
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: run clean

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -qx "SIMULATION PASSED"

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)
